// ==== Makefile ====
# Verilator build and run for the MIPS control decoder

VERILATOR ?= verilator
TOP       ?= controlUnitTb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
FLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard hw/*.sv hw/*.svh tb/*.sv tb/*.svh)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+hw
+incdir+tb
hw/mipsCtrlPkg.sv
hw/mainDecoder.sv
hw/aluControl.sv
hw/controlUnit.sv
tb/controlUnitTb.sv

// ==== hw/aluControl.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_defines.svh"

module aluControl
(
    input  logic                   rType,
    input  logic                   immRegWr,
    input  logic                   opValid,
    input  logic [`FUNC_WIDTH-1:0] func,
    input  mipsCtrlPkg::aluCtr_e   immAluCtr,
    output mipsCtrlPkg::aluCtr_e   aluCtr,
    output logic                   regWr,
    output logic                   rTypeJump,
    output logic                   rTypeLink,
    output logic                   illegal
);

    import mipsCtrlPkg::*;

    aluCtr_e rAluCtr;
    logic    rRegWr;
    logic    rJump;
    logic    rLink;
    logic    funcValid;

    // R-type function decode
    always_comb
    begin
        rAluCtr   = ALU_NONE;
        rRegWr    = 1'b1;
        rJump     = 1'b0;
        rLink     = 1'b0;
        funcValid = 1'b1;

        case (funct_e'(func))
            FN_ADD:  rAluCtr = ALU_ADD;
            FN_ADDU: rAluCtr = ALU_ADDU;
            FN_SUB:  rAluCtr = ALU_SUB;
            FN_SUBU: rAluCtr = ALU_SUBU;
            FN_AND:  rAluCtr = ALU_AND;
            FN_OR:   rAluCtr = ALU_OR;
            FN_XOR:  rAluCtr = ALU_XOR;
            FN_NOR:  rAluCtr = ALU_NOR;
            FN_SLT:  rAluCtr = ALU_SLT;
            FN_SLTU: rAluCtr = ALU_SLTU;
            FN_SLL:  rAluCtr = ALU_SLL;    // shamt form
            FN_SRL:  rAluCtr = ALU_SRL;
            FN_SRA:  rAluCtr = ALU_SRA;
            FN_SLLV: rAluCtr = ALU_SLLV;   // rs form
            FN_SRLV: rAluCtr = ALU_SRLV;
            FN_SRAV: rAluCtr = ALU_SRAV;
            FN_JR:
            begin
                rRegWr = 1'b0;
                rJump  = 1'b1;
            end
            FN_JALR:
            begin
                rJump = 1'b1;
                rLink = 1'b1;   // link into rd
            end
            default:
            begin
                rRegWr    = 1'b0;
                funcValid = 1'b0;
            end
        endcase
    end

    // func only counts under R-type
    assign illegal = ~opValid | (rType & ~funcValid);

    always_comb
    begin
        if (illegal)
        begin
            aluCtr    = ALU_NONE;
            regWr     = 1'b0;
            rTypeJump = 1'b0;
            rTypeLink = 1'b0;
        end
        else if (rType)
        begin
            aluCtr    = rAluCtr;
            regWr     = rRegWr;
            rTypeJump = rJump;
            rTypeLink = rLink;
        end
        else
        begin
            aluCtr    = immAluCtr;
            regWr     = immRegWr;
            rTypeJump = 1'b0;
            rTypeLink = 1'b0;
        end
    end

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_defines.svh"

module controlUnit
(
    input  logic [`OP_WIDTH-1:0]   op,
    input  logic [`FUNC_WIDTH-1:0] func,
    output logic                   branch,
    output logic                   jump,
    output logic                   regDst,
    output logic                   aluSrc,
    output logic                   memToReg,
    output logic                   regWr,
    output logic                   memWr,
    output logic                   rType,
    output logic                   jal,
    output logic                   rTypeJump,
    output logic                   rTypeLink,
    output logic                   illegal,
    output mipsCtrlPkg::extOp_e    extOp,
    output mipsCtrlPkg::aluCtr_e   aluCtr
);

    import mipsCtrlPkg::*;

    aluCtr_e immAluCtr;
    logic    immRegWr;
    logic    opValid;
    logic    decRegDst;

    mainDecoder mainDecoder_i
    (
        .op        (op),
        .rType     (rType),
        .branch    (branch),
        .jump      (jump),
        .regDst    (decRegDst),
        .aluSrc    (aluSrc),
        .memToReg  (memToReg),
        .memWr     (memWr),
        .jal       (jal),
        .immRegWr  (immRegWr),
        .opValid   (opValid),
        .extOp     (extOp),
        .immAluCtr (immAluCtr)
    );

    aluControl aluControl_i
    (
        .rType     (rType),
        .immRegWr  (immRegWr),
        .opValid   (opValid),
        .func      (func),
        .immAluCtr (immAluCtr),
        .aluCtr    (aluCtr),
        .regWr     (regWr),
        .rTypeJump (rTypeJump),
        .rTypeLink (rTypeLink),
        .illegal   (illegal)
    );

    // undefined func under R-type clears the destination select
    assign regDst = decRegDst & ~illegal;

endmodule

// ==== hw/mainDecoder.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_defines.svh"

module mainDecoder
(
    input  logic [`OP_WIDTH-1:0] op,
    output logic                 rType,
    output logic                 branch,
    output logic                 jump,
    output logic                 regDst,
    output logic                 aluSrc,
    output logic                 memToReg,
    output logic                 memWr,
    output logic                 jal,
    output logic                 immRegWr,
    output logic                 opValid,
    output mipsCtrlPkg::extOp_e  extOp,
    output mipsCtrlPkg::aluCtr_e immAluCtr
);

    import mipsCtrlPkg::*;

    always_comb
    begin
        rType     = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        regDst    = 1'b0;
        aluSrc    = 1'b0;
        memToReg  = 1'b0;
        memWr     = 1'b0;
        jal       = 1'b0;
        immRegWr  = 1'b0;
        opValid   = 1'b1;
        extOp     = EXT_ZERO;
        immAluCtr = ALU_NONE;

        case (opcode_e'(op))
            OP_RTYPE:
            begin
                rType  = 1'b1;
                regDst = 1'b1;   // alu code and write enable come from func
            end
            OP_ADDI:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                extOp     = EXT_SIGN;
                immAluCtr = ALU_ADD;
            end
            OP_ADDIU:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                extOp     = EXT_SIGN;
                immAluCtr = ALU_ADDU;
            end
            OP_SLTI:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                extOp     = EXT_SIGN;
                immAluCtr = ALU_SLT;
            end
            OP_SLTIU:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                extOp     = EXT_SIGN;
                immAluCtr = ALU_SLTU;
            end
            OP_ANDI:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                immAluCtr = ALU_AND;   // logic ops zero extend
            end
            OP_ORI:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                immAluCtr = ALU_OR;
            end
            OP_XORI:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                immAluCtr = ALU_XOR;
            end
            OP_LUI:
            begin
                aluSrc    = 1'b1;
                immRegWr  = 1'b1;
                extOp     = EXT_UPPER;
                immAluCtr = ALU_LUI;
            end
            OP_BEQ, OP_BNE:
            begin
                branch    = 1'b1;
                immAluCtr = ALU_SUB;   // compare by subtraction
            end
            OP_REGIMM, OP_BLEZ, OP_BGTZ:
            begin
                branch = 1'b1;   // sign test outside the alu
            end
            OP_LW:
            begin
                aluSrc    = 1'b1;
                memToReg  = 1'b1;
                immRegWr  = 1'b1;
                extOp     = EXT_SIGN;
                immAluCtr = ALU_ADDU;
            end
            OP_SW:
            begin
                aluSrc    = 1'b1;
                memWr     = 1'b1;
                extOp     = EXT_SIGN;
                immAluCtr = ALU_ADDU;
            end
            OP_J:
            begin
                jump = 1'b1;
            end
            OP_JAL:
            begin
                jump     = 1'b1;
                jal      = 1'b1;
                immRegWr = 1'b1;   // return address to r31
            end
            default:
            begin
                opValid = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/mipsCtrlPkg.sv ====
`include "mipsCtrl_defines.svh"

package mipsCtrlPkg;

    typedef enum logic [`OP_WIDTH-1:0]
    {
        OP_RTYPE  = 6'b000000,
        OP_REGIMM = 6'b000001,   // bgez / bltz, selected by rt
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LW     = 6'b100011,
        OP_SW     = 6'b101011
    } opcode_e;

    typedef enum logic [`FUNC_WIDTH-1:0]
    {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [`ALUCTR_WIDTH-1:0]
    {
        ALU_ADD  = 5'd0,
        ALU_ADDU = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_SUBU = 5'd3,
        ALU_AND  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_XOR  = 5'd6,
        ALU_SLL  = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRA  = 5'd11,
        ALU_SLT  = 5'd12,
        ALU_SLTU = 5'd13,
        ALU_NOR  = 5'd14,
        ALU_SLLV = 5'd15,
        ALU_SRLV = 5'd16,
        ALU_SRAV = 5'd18,
        ALU_LUI  = 5'd30,
        ALU_NONE = 5'd31    // result not used
    } aluCtr_e;

    typedef enum logic [`EXTOP_WIDTH-1:0]
    {
        EXT_ZERO  = 2'd0,
        EXT_SIGN  = 2'd1,
        EXT_UPPER = 2'd2    // imm placed in bits 31:16
    } extOp_e;

endpackage

// ==== hw/mipsCtrl_defines.svh ====
`ifndef MIPSCTRL_DEFINES_SVH
`define MIPSCTRL_DEFINES_SVH

// instruction fields
`define OP_WIDTH      6   // bits 31:26
`define FUNC_WIDTH    6   // bits 5:0 under R-type

// control codes
`define ALUCTR_WIDTH  5
`define EXTOP_WIDTH   2   // zero, sign or upper-half immediate

`endif

// ==== tb/controlVectors.svh ====
function automatic void loadVectors();
    // columns: op, func, controls, extOp, aluCtr
    // controls = {branch jump regDst aluSrc | memToReg regWr memWr rType | jal rJump rLink illegal}
    addRow(OP_RTYPE,  FN_ADD,  12'b0010_0101_0000, EXT_ZERO,  ALU_ADD);
    addRow(OP_RTYPE,  FN_ADDU, 12'b0010_0101_0000, EXT_ZERO,  ALU_ADDU);
    addRow(OP_RTYPE,  FN_SUB,  12'b0010_0101_0000, EXT_ZERO,  ALU_SUB);
    addRow(OP_RTYPE,  FN_SUBU, 12'b0010_0101_0000, EXT_ZERO,  ALU_SUBU);
    addRow(OP_RTYPE,  FN_AND,  12'b0010_0101_0000, EXT_ZERO,  ALU_AND);
    addRow(OP_RTYPE,  FN_OR,   12'b0010_0101_0000, EXT_ZERO,  ALU_OR);
    addRow(OP_RTYPE,  FN_XOR,  12'b0010_0101_0000, EXT_ZERO,  ALU_XOR);
    addRow(OP_RTYPE,  FN_NOR,  12'b0010_0101_0000, EXT_ZERO,  ALU_NOR);
    addRow(OP_RTYPE,  FN_SLT,  12'b0010_0101_0000, EXT_ZERO,  ALU_SLT);
    addRow(OP_RTYPE,  FN_SLTU, 12'b0010_0101_0000, EXT_ZERO,  ALU_SLTU);
    addRow(OP_RTYPE,  FN_SLL,  12'b0010_0101_0000, EXT_ZERO,  ALU_SLL);
    addRow(OP_RTYPE,  FN_SRL,  12'b0010_0101_0000, EXT_ZERO,  ALU_SRL);
    addRow(OP_RTYPE,  FN_SRA,  12'b0010_0101_0000, EXT_ZERO,  ALU_SRA);
    addRow(OP_RTYPE,  FN_SLLV, 12'b0010_0101_0000, EXT_ZERO,  ALU_SLLV);
    addRow(OP_RTYPE,  FN_SRLV, 12'b0010_0101_0000, EXT_ZERO,  ALU_SRLV);
    addRow(OP_RTYPE,  FN_SRAV, 12'b0010_0101_0000, EXT_ZERO,  ALU_SRAV);
    addRow(OP_RTYPE,  FN_JR,   12'b0010_0001_0100, EXT_ZERO,  ALU_NONE);   // no write back
    addRow(OP_RTYPE,  FN_JALR, 12'b0010_0101_0110, EXT_ZERO,  ALU_NONE);
    addRow(OP_ADDI,   6'h00,   12'b0001_0100_0000, EXT_SIGN,  ALU_ADD);
    addRow(OP_ADDIU,  6'h00,   12'b0001_0100_0000, EXT_SIGN,  ALU_ADDU);
    addRow(OP_SLTI,   6'h00,   12'b0001_0100_0000, EXT_SIGN,  ALU_SLT);
    addRow(OP_SLTIU,  6'h00,   12'b0001_0100_0000, EXT_SIGN,  ALU_SLTU);
    addRow(OP_ANDI,   6'h00,   12'b0001_0100_0000, EXT_ZERO,  ALU_AND);
    addRow(OP_ORI,    6'h00,   12'b0001_0100_0000, EXT_ZERO,  ALU_OR);
    addRow(OP_XORI,   6'h00,   12'b0001_0100_0000, EXT_ZERO,  ALU_XOR);
    addRow(OP_LUI,    6'h00,   12'b0001_0100_0000, EXT_UPPER, ALU_LUI);
    addRow(OP_BEQ,    6'h00,   12'b1000_0000_0000, EXT_ZERO,  ALU_SUB);
    addRow(OP_BNE,    6'h00,   12'b1000_0000_0000, EXT_ZERO,  ALU_SUB);
    addRow(OP_REGIMM, 6'h00,   12'b1000_0000_0000, EXT_ZERO,  ALU_NONE);
    addRow(OP_BLEZ,   6'h00,   12'b1000_0000_0000, EXT_ZERO,  ALU_NONE);
    addRow(OP_BGTZ,   6'h00,   12'b1000_0000_0000, EXT_ZERO,  ALU_NONE);
    addRow(OP_LW,     6'h00,   12'b0001_1100_0000, EXT_SIGN,  ALU_ADDU);
    addRow(OP_SW,     6'h00,   12'b0001_0010_0000, EXT_SIGN,  ALU_ADDU);
    addRow(OP_J,      6'h00,   12'b0100_0000_0000, EXT_ZERO,  ALU_NONE);
    addRow(OP_JAL,    6'h00,   12'b0100_0100_1000, EXT_ZERO,  ALU_NONE);   // link to r31
endfunction

// ==== tb/controlUnitTb.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_defines.svh"

module controlUnitTb;

    import mipsCtrlPkg::*;

    localparam int EDGE_TIMEOUT  = 40;    // ns, two clock periods
    localparam int RANDOM_ROWS   = 64;
    localparam int ILLEGAL_TRIES = 32;
    localparam int PICK_LIMIT    = 200;

    typedef struct
    {
        logic [`OP_WIDTH-1:0]   op;
        logic [`FUNC_WIDTH-1:0] func;
        logic [11:0]            ctl;
        extOp_e                 extOp;
        aluCtr_e                aluCtr;
    } vector_t;

    logic                   clk;
    logic                   arstN;
    logic [`OP_WIDTH-1:0]   op;
    logic [`FUNC_WIDTH-1:0] func;
    logic                   branch;
    logic                   jump;
    logic                   regDst;
    logic                   aluSrc;
    logic                   memToReg;
    logic                   regWr;
    logic                   memWr;
    logic                   rType;
    logic                   jal;
    logic                   rTypeJump;
    logic                   rTypeLink;
    logic                   illegal;
    extOp_e                 extOp;
    aluCtr_e                aluCtr;

    vector_t vectors[$];

    always #10 clk = ~clk;

    controlUnit controlUnit_i
    (
        .op        (op),
        .func      (func),
        .branch    (branch),
        .jump      (jump),
        .regDst    (regDst),
        .aluSrc    (aluSrc),
        .memToReg  (memToReg),
        .regWr     (regWr),
        .memWr     (memWr),
        .rType     (rType),
        .jal       (jal),
        .rTypeJump (rTypeJump),
        .rTypeLink (rTypeLink),
        .illegal   (illegal),
        .extOp     (extOp),
        .aluCtr    (aluCtr)
    );

    function automatic void addRow(input logic [`OP_WIDTH-1:0] opIn,
                                   input logic [`FUNC_WIDTH-1:0] funcIn,
                                   input logic [11:0] ctlIn, input extOp_e extIn,
                                   input aluCtr_e aluIn);
        vector_t row;
        row.op     = opIn;
        row.func   = funcIn;
        row.ctl    = ctlIn;
        row.extOp  = extIn;
        row.aluCtr = aluIn;
        vectors.push_back(row);
    endfunction

    `include "controlVectors.svh"

    function automatic bit isTableOp(input logic [`OP_WIDTH-1:0] opIn);
        foreach (vectors[i])
            if (vectors[i].op == opIn)
                return 1'b1;
        return 1'b0;
    endfunction

    function automatic bit isTableFunc(input logic [`FUNC_WIDTH-1:0] funcIn);
        foreach (vectors[i])
            if (vectors[i].op == OP_RTYPE && vectors[i].func == funcIn)
                return 1'b1;
        return 1'b0;
    endfunction

    // polls in 1 ns steps until clk moves to level
    task automatic waitClockEdge(input logic level);
        int   steps;
        logic prev;
        logic seen;
        steps = 0;
        seen  = 1'b0;
        prev  = clk;
        while (!seen && steps < EDGE_TIMEOUT)
        begin
            #1;
            steps++;
            if (prev !== level && clk === level)
                seen = 1'b1;
            prev = clk;
        end
        if (!seen)
        begin
            $display("clock edge not seen within %0d ns, the clock has stopped", EDGE_TIMEOUT);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERR %s: expected 0x%0h, got 0x%0h (op 0x%0h func 0x%0h)",
                     name, expected, actual, op, func);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic checkAluCtr(input aluCtr_e expected, input aluCtr_e actual);
        if (actual !== expected)
        begin
            $display("ERR aluCtr: expected 0x%0h, got 0x%0h (op 0x%0h func 0x%0h)",
                     expected, actual, op, func);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic checkExtOp(input extOp_e expected, input extOp_e actual);
        if (actual !== expected)
        begin
            $display("ERR extOp: expected 0x%0h, got 0x%0h (op 0x%0h func 0x%0h)",
                     expected, actual, op, func);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic driveInputs(input logic [`OP_WIDTH-1:0] opIn,
                               input logic [`FUNC_WIDTH-1:0] funcIn);
        waitClockEdge(1'b0);
        op   = opIn;
        func = funcIn;
    endtask

    task automatic checkControls(input logic [11:0] ctl, input extOp_e expExt,
                                 input aluCtr_e expAlu);
        waitClockEdge(1'b1);
        checkBit("branch", ctl[11], branch);
        checkBit("jump", ctl[10], jump);
        checkBit("regDst", ctl[9], regDst);
        checkBit("aluSrc", ctl[8], aluSrc);
        checkBit("memToReg", ctl[7], memToReg);
        checkBit("regWr", ctl[6], regWr);
        checkBit("memWr", ctl[5], memWr);
        checkBit("rType", ctl[4], rType);
        checkBit("jal", ctl[3], jal);
        checkBit("rTypeJump", ctl[2], rTypeJump);
        checkBit("rTypeLink", ctl[1], rTypeLink);
        checkBit("illegal", ctl[0], illegal);
        checkExtOp(expExt, extOp);
        checkAluCtr(expAlu, aluCtr);
    endtask

    initial
    begin
        int                     idx;
        int                     picks;
        int                     nonR[$];
        logic [`OP_WIDTH-1:0]   opRand;
        logic [`FUNC_WIDTH-1:0] funcRand;

        clk   = 1'b0;
        arstN = 1'b0;   // low for the first three cycles
        op    = '0;
        func  = '0;
        void'($urandom(32'h3328f4ae));
        loadVectors();

        repeat (3) waitClockEdge(1'b1);
        arstN = 1'b1;

        foreach (vectors[i])   // directed table
        begin
            driveInputs(vectors[i].op, vectors[i].func);
            checkControls(vectors[i].ctl, vectors[i].extOp, vectors[i].aluCtr);
        end

        foreach (vectors[i])
            if (vectors[i].op != OP_RTYPE)
                nonR.push_back(i);

        for (int n = 0; n < RANDOM_ROWS; n++)   // func must not matter here
        begin
            idx = nonR[$urandom_range(nonR.size() - 1, 0)];
            driveInputs(vectors[idx].op, 6'($urandom));
            checkControls(vectors[idx].ctl, vectors[idx].extOp, vectors[idx].aluCtr);
        end

        for (int n = 0; n < ILLEGAL_TRIES; n++)
        begin
            picks = 0;
            do
            begin
                opRand = 6'($urandom);
                picks++;
            end while (isTableOp(opRand) && picks < PICK_LIMIT);
            if (isTableOp(opRand))
            begin
                $display("could not pick an undefined opcode after %0d tries", PICK_LIMIT);
                $display("FAIL: see errors above");
                $fatal(1, "no undefined opcode");
            end
            driveInputs(opRand, 6'($urandom));
            checkControls(12'b0000_0000_0001, EXT_ZERO, ALU_NONE);
        end

        for (int n = 0; n < ILLEGAL_TRIES; n++)
        begin
            picks = 0;
            do
            begin
                funcRand = 6'($urandom);
                picks++;
            end while (isTableFunc(funcRand) && picks < PICK_LIMIT);
            if (isTableFunc(funcRand))
            begin
                $display("could not pick an undefined function after %0d tries", PICK_LIMIT);
                $display("FAIL: see errors above");
                $fatal(1, "no undefined function");
            end
            driveInputs(OP_RTYPE, funcRand);
            checkControls(12'b0000_0001_0001, EXT_ZERO, ALU_NONE);   // rType stays set
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
